/* Makefile */
# Verilator build, run, lint and clean for the arcade I/O glue

VERILATOR ?= verilator
TOP       ?= tb_arcade_io_top
RTL_TOP   ?= arcade_io_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(filter-out +incdir%,$(shell cat $(FILELIST)))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(EXE) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || { echo "FAIL: no result"; exit 1; }
	@echo "PASS"

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* arcade_io_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions on the AXI handshakes and SRAM control
// Bound into every arcade_io_top instance
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module arcade_io_checker (
  input logic clk12,
  input logic pll_lckd,
  input logic s_axil_awvalid,
  input logic s_axil_wvalid,
  input logic s_axil_awready,
  input logic s_axil_bvalid,
  input logic s_axil_bready,
  input logic s_axil_rvalid,
  input logic s_axil_rready,
  input logic por_active,
  input logic sram_we_n
);

  int unsigned fail_count = 0;  // Failed assertions so far

  bvalid_held: assert property (@(posedge clk12) disable iff (!pll_lckd)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  rvalid_held: assert property (@(posedge clk12) disable iff (!pll_lckd)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
    else begin
      fail_count++;
      $error("rvalid dropped before rready");
    end

  // Power-on fetch owns the SRAM, nothing may write it
  no_write_in_por: assert property (@(posedge clk12) disable iff (!pll_lckd)
    por_active |-> sram_we_n)
    else begin
      fail_count++;
      $error("SRAM write during the power-on window");
    end

  awready_needs_both: assert property (@(posedge clk12) disable iff (!pll_lckd)
    s_axil_awready |-> s_axil_awvalid && s_axil_wvalid)
    else begin
      fail_count++;
      $error("awready high without both awvalid and wvalid");
    end

endmodule

bind arcade_io_top arcade_io_checker i_arcade_io_checker (.*);

/* arcade_io_top.sv */
////////////////////////////////////////////////////////////////////////////
// Arcade board glue top level
// Reset, ROM loading, SRAM sharing, JAMMA joysticks and audio DAC
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module arcade_io_top (
  input  logic                          clk12,
  input  logic                          pll_lckd,
  // Host register port
  input  logic [3:0]                    s_axil_awaddr,
  input  logic                          s_axil_awvalid,
  output logic                          s_axil_awready,
  input  logic [31:0]                   s_axil_wdata,
  input  logic                          s_axil_wvalid,
  output logic                          s_axil_wready,
  output logic [1:0]                    s_axil_bresp,
  output logic                          s_axil_bvalid,
  input  logic                          s_axil_bready,
  input  logic [3:0]                    s_axil_araddr,
  input  logic                          s_axil_arvalid,
  output logic                          s_axil_arready,
  output logic [31:0]                   s_axil_rdata,
  output logic [1:0]                    s_axil_rresp,
  output logic                          s_axil_rvalid,
  input  logic                          s_axil_rready,
  // SRAM pins, data bus split in and out
  output logic [board_pkg::SRAM_AW-1:0] sram_addr,
  output logic [7:0]                    sram_dout,
  input  logic [7:0]                    sram_din,
  output logic                          sram_we_n,
  // JAMMA
  input  logic [7:0]                    jjoy,
  output logic                          jselect,
  input  logic                          test_n,
  // Game core side
  input  logic [board_pkg::SRAM_AW-1:0] core_rd_addr,
  output logic [7:0]                    core_rd_data,
  output logic                          core_reset,
  output board_pkg::joy_state_t         joy_p1,
  output board_pkg::joy_state_t         joy_p2,
  output logic [1:0]                    scandbl_ctrl,
  input  audio_pkg::sample_t            audio_sample,
  output logic                          audio_out
);

  logic                 por_active;
  logic                 loading;
  logic [7:0]           cfg_byte;
  board_pkg::sram_req_t wr_req;
  logic                 wr_valid;
  logic                 wr_ready;
  audio_pkg::sample_t   sample_q;

  reset_sequencer i_reset_sequencer (
    .clk12, .pll_lckd, .test_n, .loading, .cfg_byte,
    .por_active, .core_reset, .scandbl_ctrl
  );

  jamma_joy_demux i_jamma_joy_demux (.clk12, .pll_lckd, .jjoy, .jselect, .joy_p1, .joy_p2);

  rom_loader_axil i_rom_loader_axil (
    .clk12, .pll_lckd,
    .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
    .s_axil_wdata, .s_axil_wvalid, .s_axil_wready,
    .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
    .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
    .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
    .wr_req, .wr_valid, .wr_ready, .loading
  );

  sram_arbiter i_sram_arbiter (
    .clk12, .pll_lckd, .por_active, .wr_req, .wr_valid, .wr_ready,
    .core_rd_addr, .core_rd_data, .cfg_byte,
    .sram_addr, .sram_dout, .sram_din, .sram_we_n
  );

  ////////////////////////////////////////////////////////////////////////////
  // Audio
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk12 or negedge pll_lckd) begin
    if (!pll_lckd) begin
      sample_q <= '0;
    end else begin
      sample_q <= audio_sample;  // Retime the core's sample
    end
  end

  sigma_delta_dac i_sigma_delta_dac (.clk12, .pll_lckd, .sample(sample_q), .dac_out(audio_out));

endmodule

/* audio_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Audio sample type and DAC width
// Shared by the top level and the sigma-delta modulator
////////////////////////////////////////////////////////////////////////////

package audio_pkg;

  // Width of the core's unsigned audio samples
  localparam int unsigned DAC_W = 8;

  // One audio sample, 0 is silence at the low rail
  typedef logic [DAC_W-1:0] sample_t;

endpackage

/* board_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Board-level types and constants for the arcade I/O glue
// Joystick state, SRAM request, reset timing and AXI register map
////////////////////////////////////////////////////////////////////////////

package board_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // SRAM
  ////////////////////////////////////////////////////////////////////////////
  localparam int unsigned SRAM_AW = 19;                  // 512K x 8 part
  localparam logic [SRAM_AW-1:0] CONFIG_ADDR = 19'h08FD5; // Video config byte

  ////////////////////////////////////////////////////////////////////////////
  // Reset timing, in clk12 cycles
  ////////////////////////////////////////////////////////////////////////////
  localparam int unsigned POR_CYCLES    = 64;  // Power-on window length
  localparam int unsigned CONFIG_SAMPLE = 32;  // Config byte sampled here
  localparam int unsigned HOLD_CYCLES   = 256; // Core reset tail

  // AXI register byte offsets
  localparam logic [3:0] REG_CTRL = 4'h0;
  localparam logic [3:0] REG_ADDR = 4'h4;
  localparam logic [3:0] REG_DATA = 4'h8;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // One player, all buttons active low
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
    logic fire1;
    logic fire2;
    logic fire3;
    logic start;
  } joy_state_t;

  // One SRAM access as seen on the pins
  typedef struct packed {
    logic [SRAM_AW-1:0] addr;
    logic [7:0]         wdata;
    logic               we;     // High for a byte write
  } sram_req_t;

endpackage

/* files.f */
board_pkg.sv
audio_pkg.sv
reset_sequencer.sv
jamma_joy_demux.sv
rom_loader_axil.sv
sram_arbiter.sv
sigma_delta_dac.sv
arcade_io_top.sv
arcade_io_checker.sv
tb_arcade_io_top.sv

/* jamma_joy_demux.sv */
////////////////////////////////////////////////////////////////////////////
// JAMMA joystick demultiplexer
// Alternates the external mux select and splits the bus into two players
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jamma_joy_demux (
  input  logic                  clk12,
  input  logic                  pll_lckd,
  input  logic [7:0]            jjoy,      // Shared bus, player set by jselect
  output logic                  jselect,   // Low selects player 1
  output board_pkg::joy_state_t joy_p1,
  output board_pkg::joy_state_t joy_p2
);

  // Select toggles every cycle, so each player refreshes every other cycle
  always_ff @(posedge clk12 or negedge pll_lckd) begin
    if (!pll_lckd) begin
      jselect <= 1'b0;
      joy_p1  <= '1;   // Nothing pressed
      joy_p2  <= '1;
    end else begin
      jselect <= ~jselect;
      if (!jselect) begin
        joy_p1 <= board_pkg::joy_state_t'(jjoy);
      end else begin
        joy_p2 <= board_pkg::joy_state_t'(jjoy);
      end
    end
  end

endmodule

/* reset_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Reset sequencing after PLL lock
// Opens the power-on window, samples the video config and holds the core
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reset_sequencer (
  input  logic       clk12,
  input  logic       pll_lckd,
  input  logic       test_n,       // JAMMA test switch, low forces reset
  input  logic       loading,      // ROM load in progress
  input  logic [7:0] cfg_byte,     // Registered SRAM data
  output logic       por_active,
  output logic       core_reset,
  output logic [1:0] scandbl_ctrl
);

  logic [6:0] por_cnt;
  logic [8:0] hold_cnt;
  logic       rst_cause;

  ////////////////////////////////////////////////////////////////////////////
  // Power-on window
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk12 or negedge pll_lckd) begin
    if (!pll_lckd) begin
      por_cnt      <= '0;
      por_active   <= 1'b1;
      scandbl_ctrl <= 2'b00;
    end else if (por_active) begin
      por_cnt <= por_cnt + 7'd1;
      // SRAM has sat on the config address long enough by now
      if (por_cnt == 7'(board_pkg::CONFIG_SAMPLE)) begin
        scandbl_ctrl <= cfg_byte[1:0];
      end
      if (por_cnt == 7'(board_pkg::POR_CYCLES - 1)) begin
        por_active <= 1'b0;  // Window closes, SRAM free for others
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Core reset hold
  ////////////////////////////////////////////////////////////////////////////
  assign rst_cause = por_active | loading | ~test_n;

  // Counter restarts on any cause and saturates at the hold length
  always_ff @(posedge clk12 or negedge pll_lckd) begin
    if (!pll_lckd) begin
      hold_cnt <= '0;
    end else if (rst_cause) begin
      hold_cnt <= '0;
    end else if (hold_cnt != 9'(board_pkg::HOLD_CYCLES)) begin
      hold_cnt <= hold_cnt + 9'd1;
    end
  end

  assign core_reset = rst_cause | (hold_cnt != 9'(board_pkg::HOLD_CYCLES));

endmodule

/* rom_loader_axil.sv */
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite ROM loader
// CTRL holds the loading flag, ADDR the SRAM pointer, DATA writes one byte
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_loader_axil (
  input  logic                 clk12,
  input  logic                 pll_lckd,
  input  logic [3:0]           s_axil_awaddr,
  input  logic                 s_axil_awvalid,
  output logic                 s_axil_awready,
  input  logic [31:0]          s_axil_wdata,
  input  logic                 s_axil_wvalid,
  output logic                 s_axil_wready,
  output logic [1:0]           s_axil_bresp,
  output logic                 s_axil_bvalid,
  input  logic                 s_axil_bready,
  input  logic [3:0]           s_axil_araddr,
  input  logic                 s_axil_arvalid,
  output logic                 s_axil_arready,
  output logic [31:0]          s_axil_rdata,
  output logic [1:0]           s_axil_rresp,
  output logic                 s_axil_rvalid,
  input  logic                 s_axil_rready,
  output board_pkg::sram_req_t wr_req,
  output logic                 wr_valid,
  input  logic                 wr_ready,
  output logic                 loading
);

  logic [board_pkg::SRAM_AW-1:0] addr_q;
  logic                          wr_both;
  logic                          byte_pending;
  logic                          wr_accept;
  logic                          rd_accept;

  function automatic logic reg_known(input logic [3:0] off);
    return (off == board_pkg::REG_CTRL) || (off == board_pkg::REG_ADDR) ||
           (off == board_pkg::REG_DATA);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////////////////////
  assign wr_both      = s_axil_awvalid & s_axil_wvalid & ~s_axil_bvalid;
  assign wr_valid     = wr_both & (s_axil_awaddr == board_pkg::REG_DATA);
  assign byte_pending = wr_valid & ~wr_ready;  // Arbiter busy with power-on fetch
  assign wr_accept    = wr_both & ~byte_pending;

  assign s_axil_awready = wr_accept;
  assign s_axil_wready  = wr_accept;

  // Byte goes straight to the arbiter, which registers it onto the pins
  assign wr_req = '{addr: addr_q, wdata: s_axil_wdata[7:0], we: 1'b1};

  assign s_axil_arready = ~s_axil_rvalid;
  assign rd_accept      = s_axil_arvalid & s_axil_arready;

  always_ff @(posedge clk12 or negedge pll_lckd) begin
    if (!pll_lckd) begin
      loading       <= 1'b0;
      addr_q        <= '0;
      s_axil_bvalid <= 1'b0;
      s_axil_rvalid <= 1'b0;
    end else begin
      if (s_axil_bready) s_axil_bvalid <= 1'b0;
      if (s_axil_rready) s_axil_rvalid <= 1'b0;
      if (rd_accept) s_axil_rvalid <= 1'b1;
      if (wr_accept) begin
        s_axil_bvalid <= 1'b1;
        case (s_axil_awaddr)
          board_pkg::REG_CTRL: loading <= s_axil_wdata[0];
          board_pkg::REG_ADDR: addr_q  <= s_axil_wdata[board_pkg::SRAM_AW-1:0];
          board_pkg::REG_DATA: addr_q  <= addr_q + {{(board_pkg::SRAM_AW-1){1'b0}}, 1'b1};
          default: ;  // Unknown offset, answered with SLVERR only
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response payloads
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk12) begin
    if (wr_accept) begin
      s_axil_bresp <= reg_known(s_axil_awaddr) ? board_pkg::RESP_OKAY : board_pkg::RESP_SLVERR;
    end
    if (rd_accept) begin
      s_axil_rresp <= reg_known(s_axil_araddr) ? board_pkg::RESP_OKAY : board_pkg::RESP_SLVERR;
      case (s_axil_araddr)
        board_pkg::REG_CTRL: s_axil_rdata <= {31'd0, loading};
        board_pkg::REG_ADDR: s_axil_rdata <= 32'(addr_q);
        default:             s_axil_rdata <= 32'd0;  // DATA is write-only
      endcase
    end
  end

endmodule

/* sigma_delta_dac.sv */
////////////////////////////////////////////////////////////////////////////
// First-order sigma-delta DAC
// Density of ones on dac_out tracks sample / 2**DAC_W
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sigma_delta_dac (
  input  logic               clk12,
  input  logic               pll_lckd,
  input  audio_pkg::sample_t sample,
  output logic               dac_out
);

  logic [audio_pkg::DAC_W:0] acc;  // Top bit is the carry out

  // Carry is dropped before each add, only the residue is kept
  always_ff @(posedge clk12 or negedge pll_lckd) begin
    if (!pll_lckd) begin
      acc <= '0;
    end else begin
      acc <= {1'b0, acc[audio_pkg::DAC_W-1:0]} + {1'b0, sample};
    end
  end

  assign dac_out = acc[audio_pkg::DAC_W];

endmodule

/* sram_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// SRAM arbiter
// Fixed priority: power-on fetch, loader write, then core read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_arbiter (
  input  logic                          clk12,
  input  logic                          pll_lckd,
  input  logic                          por_active,
  input  board_pkg::sram_req_t          wr_req,
  input  logic                          wr_valid,
  output logic                          wr_ready,
  input  logic [board_pkg::SRAM_AW-1:0] core_rd_addr,
  output logic [7:0]                    core_rd_data,
  output logic [7:0]                    cfg_byte,
  output logic [board_pkg::SRAM_AW-1:0] sram_addr,
  output logic [7:0]                    sram_dout,
  input  logic [7:0]                    sram_din,
  output logic                          sram_we_n
);

  board_pkg::sram_req_t pin_d;
  board_pkg::sram_req_t pin_q;     // Access currently on the pins
  logic [7:0]           din_q;
  logic                 wr_seen;   // Sampled data came from a write cycle

  assign wr_ready = ~por_active;   // Loader only waits out the power-on window

  always_comb begin
    pin_d = '{addr: core_rd_addr, wdata: 8'h00, we: 1'b0};
    if (por_active) begin
      pin_d.addr = board_pkg::CONFIG_ADDR;
    end else if (wr_valid) begin
      pin_d = wr_req;
    end
  end

  always_ff @(posedge clk12 or negedge pll_lckd) begin
    if (!pll_lckd) begin
      pin_q   <= '{addr: board_pkg::CONFIG_ADDR, wdata: 8'h00, we: 1'b0};
      wr_seen <= 1'b0;
    end else begin
      pin_q   <= pin_d;
      wr_seen <= pin_q.we;
    end
  end

  always_ff @(posedge clk12) begin
    din_q <= sram_din;
  end

  assign sram_addr = pin_q.addr;
  assign sram_dout = pin_q.wdata;
  assign sram_we_n = ~pin_q.we;

  assign cfg_byte     = din_q;
  assign core_rd_data = wr_seen ? 8'h00 : din_q;  // Bus held our own data

endmodule

/* tb_arcade_io_top.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the arcade I/O glue top level
// SRAM model, random AXI, JAMMA, core read and audio stimulus with checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_arcade_io_top;

  localparam int N_LOAD  = 24;   // Bytes written through the loader
  localparam int N_READ  = 48;
  localparam int N_JOY   = 40;
  localparam int N_AUDIO = 6;    // Samples, each held 256 cycles
  localparam int HOLD    = board_pkg::HOLD_CYCLES;
  localparam int TEST_CYCLES = 5 + board_pkg::POR_CYCLES + 3 * (HOLD + 8) +
                               8 * (N_LOAD + 8) + N_READ + N_JOY + N_AUDIO * 256 + 64;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES;
  localparam logic [7:0] CFG_BYTE = 8'h5E;

  logic        clk12, pll_lckd, test_n;
  logic [3:0]  s_axil_awaddr, s_axil_araddr;
  logic [31:0] s_axil_wdata, s_axil_rdata;
  logic        s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
  logic [1:0]  s_axil_bresp, s_axil_rresp;
  logic        s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
  logic        s_axil_rvalid, s_axil_rready;
  logic [board_pkg::SRAM_AW-1:0] sram_addr, core_rd_addr, load_start, next_addr;
  logic [7:0]  sram_dout, sram_din, jjoy, core_rd_data;
  logic        sram_we_n, jselect, core_reset, audio_out;
  logic [1:0]  scandbl_ctrl;
  board_pkg::joy_state_t     joy_p1, joy_p2;
  audio_pkg::sample_t        audio_sample, sample_ref;
  int          acc_ref;     // Reference accumulator residue, below 2**DAC_W
  logic [7:0]  mem [0:(1 << board_pkg::SRAM_AW)-1];
  logic [31:0] rng_state = 32'h4a11_c20e;
  int          checks, errors, cycle_count;

  arcade_io_top i_arcade_io_top (.*);

  initial begin
    clk12 = 1'b0;
    forever #10 clk12 = ~clk12;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Response wait of 0 to 3 cycles, upper LCG bits
  function automatic int random_stall();
    logic [31:0] r;
    r = next_random();
    return int'(r[31:30]);
  endfunction

  function automatic logic [7:0] fill_byte(input logic [board_pkg::SRAM_AW-1:0] a);
    return a[7:0] ^ a[15:8] ^ {5'd0, a[18:16]} ^ 8'h3C;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // SRAM model, asynchronous read and write on the rising edge
  ////////////////////////////////////////////////////////////////////////////
  assign sram_din = mem[sram_addr];

  initial begin : sram_model
    for (int a = 0; a < (1 << board_pkg::SRAM_AW); a++) begin
      mem[a] <= fill_byte(board_pkg::SRAM_AW'(a));
    end
    mem[board_pkg::CONFIG_ADDR] <= CFG_BYTE;  // Video config preload
    forever begin
      @(posedge clk12);
      if (!sram_we_n) mem[sram_addr] <= sram_dout;
    end
  end

  always @(posedge clk12) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Called and returns on a falling edge, as do all tasks below
  // A nonzero stall sends AW a cycle ahead of W and holds bready low
  task automatic write_reg(input logic [3:0] off, input logic [31:0] data,
                           input int stall, output logic [1:0] resp);
    s_axil_awaddr  = off;
    s_axil_wdata   = data;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = (stall == 0);
    if (stall > 0) begin
      @(posedge clk12);
      compare_value("s_axil_awready", {31'd0, s_axil_awready}, 32'd0);
      @(negedge clk12);
      s_axil_wvalid = 1'b1;
    end
    // Ready comes from inputs and registers only, steady at the rising edge
    do @(posedge clk12); while (!s_axil_awready);
    compare_value("s_axil_wready", {31'd0, s_axil_wready}, 32'd1);
    @(negedge clk12);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    compare_value("s_axil_bvalid", {31'd0, s_axil_bvalid}, 32'd1);
    resp           = s_axil_bresp;
    if (stall > 0) begin
      s_axil_bready = 1'b0;
      repeat (stall) @(negedge clk12);
      compare_value("s_axil_bvalid", {31'd0, s_axil_bvalid}, 32'd1);  // Held for bready
      s_axil_bready = 1'b1;
      @(negedge clk12);
      compare_value("s_axil_bvalid", {31'd0, s_axil_bvalid}, 32'd0);
    end
  endtask

  task automatic read_reg(input logic [3:0] off, input int stall,
                          output logic [31:0] data, output logic [1:0] resp);
    s_axil_araddr  = off;
    s_axil_arvalid = 1'b1;
    do @(posedge clk12); while (!s_axil_arready);
    @(negedge clk12);
    s_axil_arvalid = 1'b0;
    compare_value("s_axil_rvalid", {31'd0, s_axil_rvalid}, 32'd1);
    data           = s_axil_rdata;
    resp           = s_axil_rresp;
    if (stall > 0) begin
      s_axil_rready = 1'b0;
      repeat (stall) @(negedge clk12);
      compare_value("s_axil_rvalid", {31'd0, s_axil_rvalid}, 32'd1);  // Held for rready
      s_axil_rready = 1'b1;
      @(negedge clk12);
      compare_value("s_axil_rvalid", {31'd0, s_axil_rvalid}, 32'd0);
    end
  endtask

  task automatic count_release(output int cnt);
    cnt = 0;
    while (core_reset) begin
      @(negedge clk12);
      cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test steps
  ////////////////////////////////////////////////////////////////////////////
  task automatic load_rom();
    logic [1:0]  resp;
    logic [31:0] r;
    logic [7:0]  bytes [N_LOAD];
    write_reg(board_pkg::REG_CTRL, 32'd1, random_stall(), resp);
    compare_value("core_reset", {31'd0, core_reset}, 32'd1);  // Held while loading
    r = next_random();
    load_start = r[board_pkg::SRAM_AW-1:0];
    write_reg(board_pkg::REG_ADDR, r, random_stall(), resp);
    for (int i = 0; i < N_LOAD; i++) begin
      r = next_random();
      bytes[i] = r[7:0];
      write_reg(board_pkg::REG_DATA, r, random_stall(), resp);
      compare_value("s_axil_bresp", {30'd0, resp}, 32'd0);
    end
    repeat (2) @(negedge clk12);  // Last byte reaches the array
    for (int i = 0; i < N_LOAD; i++) begin
      next_addr = load_start + board_pkg::SRAM_AW'(i);
      compare_value($sformatf("sram[%05h]", next_addr), {24'd0, mem[next_addr]},
                    {24'd0, bytes[i]});
    end
    next_addr = load_start + board_pkg::SRAM_AW'(N_LOAD);
    read_reg(board_pkg::REG_ADDR, random_stall(), r, resp);
    compare_value("s_axil_rdata", r, 32'(next_addr));
    read_reg(board_pkg::REG_CTRL, random_stall(), r, resp);
    compare_value("s_axil_rdata", r, 32'd1);
    write_reg(4'hC, next_random(), random_stall(), resp);
    compare_value("s_axil_bresp", {30'd0, resp}, 32'd2);
    read_reg(4'hC, random_stall(), r, resp);
    compare_value("s_axil_rresp", {30'd0, resp}, 32'd2);
    read_reg(board_pkg::REG_ADDR, random_stall(), r, resp);
    compare_value("s_axil_rdata", r, 32'(next_addr));  // Unknown write left ADDR alone
  endtask

  task automatic core_reads();
    logic [board_pkg::SRAM_AW-1:0] addrs[$];
    logic [board_pkg::SRAM_AW-1:0] a;
    logic [31:0] r;
    logic [7:0]  offs;
    for (int i = 0; i < N_READ + 2; i++) begin
      if (i >= 2) begin
        a = addrs.pop_front();
        compare_value("core_rd_data", {24'd0, core_rd_data}, {24'd0, mem[a]});
      end
      if (i < N_READ) begin
        r = next_random();
        offs = r[8:1] % 8'(N_LOAD);
        a = r[0] ? load_start + board_pkg::SRAM_AW'(offs) : r[31:13];  // Half hit new bytes
        core_rd_addr = a;
        addrs.push_back(a);
      end
      @(negedge clk12);
    end
  endtask

  task automatic joystick_capture();
    logic [7:0]  val;
    logic        sel;
    logic [31:0] r;
    for (int i = 0; i <= N_JOY; i++) begin
      if (i > 0) compare_value("jselect", {31'd0, jselect}, {31'd0, ~sel});
      if (i > 0 && sel) compare_value("joy_p2", {24'd0, joy_p2}, {24'd0, val});
      if (i > 0 && !sel) compare_value("joy_p1", {24'd0, joy_p1}, {24'd0, val});
      r    = next_random();
      val  = r[7:0];
      sel  = jselect;   // Player taken on the next rising edge
      jjoy = val;
      @(negedge clk12);
    end
  endtask

  task automatic audio_density(input audio_pkg::sample_t s);
    int   dut_ones;
    int   ref_ones;
    logic carry;
    dut_ones     = 0;
    ref_ones     = 0;
    audio_sample = s;
    repeat (256) begin
      @(posedge clk12);
      // A one is emitted each time the running sum wraps past full scale
      acc_ref    = acc_ref + int'(sample_ref);
      carry      = (acc_ref >= (1 << audio_pkg::DAC_W));
      if (carry) acc_ref = acc_ref - (1 << audio_pkg::DAC_W);
      sample_ref = audio_sample;
      @(negedge clk12);
      if (carry) ref_ones++;
      if (audio_out) dut_ones++;
    end
    compare_value("audio_out ones", dut_ones, ref_ones);
  endtask

  initial begin
    int          cnt;
    int          assert_fails;
    logic [1:0]  resp;
    logic [31:0] r;
    {pll_lckd, s_axil_awvalid, s_axil_wvalid, s_axil_arvalid} = '0;
    {s_axil_awaddr, s_axil_araddr, s_axil_wdata} = '0;
    {s_axil_bready, s_axil_rready, test_n} = 3'b111;
    {core_rd_addr, jjoy, audio_sample, sample_ref} = '0;
    acc_ref = 0;
    {checks, errors, cycle_count} = '0;
    repeat (5) @(negedge clk12);
    pll_lckd = 1'b1;
    @(negedge clk12);
    compare_value("core_reset", {31'd0, core_reset}, 32'd1);
    while (i_arcade_io_top.por_active) @(negedge clk12);
    count_release(cnt);
    compare_value("core_reset hold after power-on", cnt, HOLD);
    compare_value("scandbl_ctrl", {30'd0, scandbl_ctrl}, {30'd0, CFG_BYTE[1:0]});
    load_rom();
    core_reads();
    write_reg(board_pkg::REG_CTRL, 32'd0, 0, resp);  // No stall, count starts at acceptance
    count_release(cnt);
    compare_value("core_reset hold after loading", cnt, HOLD);
    test_n = 1'b0;
    repeat (3) @(negedge clk12);
    compare_value("core_reset", {31'd0, core_reset}, 32'd1);
    test_n = 1'b1;
    count_release(cnt);
    compare_value("core_reset hold after test_n", cnt, HOLD);
    joystick_capture();
    for (int k = 0; k < N_AUDIO; k++) begin
      r = next_random();
      audio_density(r[15:8]);
    end
    assert_fails = i_arcade_io_top.i_arcade_io_checker.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
